// File: mmio_pkg.sv
`default_nettype none

package mmio_pkg;

  // Bus widths
  localparam int DWIDTH = 32;
  localparam int AWIDTH = 32;

  // Register map
  localparam logic [AWIDTH-1:0] ADDR_UART_STAT = 32'h8000_0000;
  localparam logic [AWIDTH-1:0] ADDR_UART_RX   = 32'h8000_0004;
  localparam logic [AWIDTH-1:0] ADDR_UART_TX   = 32'h8000_0008;
  localparam logic [AWIDTH-1:0] ADDR_CYCLE_CNT = 32'h8000_0010;
  localparam logic [AWIDTH-1:0] ADDR_INST_CNT  = 32'h8000_0014;
  localparam logic [AWIDTH-1:0] ADDR_CNT_RST   = 32'h8000_0018;

  // Serial timing, kept short for simulation
  localparam int CLKS_PER_BIT = 8;
  localparam int BAUD_W = $clog2(CLKS_PER_BIT);
  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(CLKS_PER_BIT - 1);
  localparam logic [BAUD_W-1:0] BAUD_HALF = BAUD_W'(CLKS_PER_BIT / 2 - 1);

  // Start bit, 8 data bits, stop bit
  localparam int UART_FRAME_BITS = 10;
  localparam logic [3:0] TX_LAST_BIT = 4'(UART_FRAME_BITS - 1);
  localparam logic [2:0] RX_LAST_DATA = 3'd7;

  // Receiver FSM encoding
  localparam logic [1:0] RX_IDLE  = 2'd0;
  localparam logic [1:0] RX_START = 2'd1;
  localparam logic [1:0] RX_DATA  = 2'd2;
  localparam logic [1:0] RX_STOP  = 2'd3;

  // Load/store request from the processor
  typedef struct packed {
    logic [AWIDTH-1:0] addr;
    logic [DWIDTH-1:0] wdata;
    logic              re;
    logic              we;
  } mmio_req_t;

  // Decoder to UART strobes
  typedef struct packed {
    logic       tx_valid;
    logic [7:0] tx_byte;
    logic       rx_ready;
  } uart_ctrl_t;

  // UART status back to the decoder
  typedef struct packed {
    logic       tx_ready;
    logic       rx_valid;
    logic [7:0] rx_byte;
  } uart_stat_t;

endpackage

`default_nettype wire

// File: mmio_decode.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_decode (
  input  mmio_pkg::mmio_req_t              req,
  input  mmio_pkg::uart_stat_t             uart_stat,
  input  logic [mmio_pkg::DWIDTH-1:0]      cycle_cnt,
  input  logic [mmio_pkg::DWIDTH-1:0]      inst_cnt,
  output mmio_pkg::uart_ctrl_t             uart_ctrl,
  output logic                             cnt_clear,
  output logic [mmio_pkg::DWIDTH-1:0]      rdata
);

  logic hit_stat;
  logic hit_rx;
  logic hit_tx;
  logic hit_cycle;
  logic hit_inst;
  logic hit_cnt_rst;
  logic rx_pop;

  // Address match per register
  assign hit_stat    = (req.addr == mmio_pkg::ADDR_UART_STAT);
  assign hit_rx      = (req.addr == mmio_pkg::ADDR_UART_RX);
  assign hit_tx      = (req.addr == mmio_pkg::ADDR_UART_TX);
  assign hit_cycle   = (req.addr == mmio_pkg::ADDR_CYCLE_CNT);
  assign hit_inst    = (req.addr == mmio_pkg::ADDR_INST_CNT);
  assign hit_cnt_rst = (req.addr == mmio_pkg::ADDR_CNT_RST);

  // A pop only returns data when a byte is actually held
  assign rx_pop = uart_ctrl.rx_ready && uart_stat.rx_valid;

  // Peripheral strobes
  always_comb begin
    uart_ctrl.tx_byte  = req.wdata[7:0];
    // Busy transmitter drops the write
    uart_ctrl.tx_valid = hit_tx && req.we && uart_stat.tx_ready;
    uart_ctrl.rx_ready = hit_rx && req.re;
    cnt_clear          = hit_cnt_rst && req.we;
  end

  // Read data select, counters first
  always_comb begin
    if (hit_cycle) begin
      rdata = cycle_cnt;
    end else if (hit_inst) begin
      rdata = inst_cnt;
    end else if (rx_pop) begin
      rdata = {{(mmio_pkg::DWIDTH - 8){1'b0}}, uart_stat.rx_byte};
    end else if (hit_stat) begin
      rdata = {{(mmio_pkg::DWIDTH - 2){1'b0}}, uart_stat.rx_valid, uart_stat.tx_ready};
    end else begin
      rdata = '0;
    end
  end

endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
  input  logic                 clk,
  input  logic                 rst,
  input  mmio_pkg::uart_ctrl_t uart_ctrl,
  output logic                 tx_ready,
  output logic                 txd
);

  logic                        busy;
  logic [mmio_pkg::BAUD_W-1:0] baud_cnt;
  logic [3:0]                  bit_idx;
  logic [9:0]                  frame;
  logic                        start;
  logic                        bit_end;

  assign start   = !busy && uart_ctrl.tx_valid;
  assign bit_end = busy && (baud_cnt == mmio_pkg::BAUD_LAST);

  assign tx_ready = !busy;
  // Line idles high between frames
  assign txd = busy ? frame[0] : 1'b1;

  // Bit timing and frame sequencing
  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else if (start) begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else if (bit_end) begin
      baud_cnt <= '0;
      if (bit_idx == mmio_pkg::TX_LAST_BIT) begin
        // Stop bit done
        busy <= 1'b0;
      end else begin
        bit_idx <= bit_idx + 4'd1;
      end
    end else if (busy) begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // Frame shifter, LSB goes out first
  always_ff @(posedge clk) begin
    if (start) begin
      frame <= {1'b1, uart_ctrl.tx_byte, 1'b0};
    end else if (bit_end) begin
      frame <= {1'b1, frame[9:1]};
    end
  end

endmodule

`default_nettype wire

// File: uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
  input  logic       clk,
  input  logic       rst,
  input  logic       rxd,
  input  logic       rx_ready,
  output logic       rx_valid,
  output logic [7:0] rx_byte
);

  logic                        rxd_meta;
  logic                        rxd_sync;
  logic                        rxd_prev;
  logic [1:0]                  state;
  logic [mmio_pkg::BAUD_W-1:0] baud_cnt;
  logic [2:0]                  bit_idx;
  logic [7:0]                  shift;
  logic                        frame_done;

  // Two-flop synchroniser plus one more stage for edge detect
  always_ff @(posedge clk) begin
    if (rst) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  // Good stop bit seen at mid-bit
  assign frame_done = (state == mmio_pkg::RX_STOP) && (baud_cnt == mmio_pkg::BAUD_LAST) &&
                      rxd_sync;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= mmio_pkg::RX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else begin
      case (state)
        mmio_pkg::RX_IDLE: begin
          baud_cnt <= '0;
          if (rxd_prev && !rxd_sync) begin
            state <= mmio_pkg::RX_START;
          end
        end
        mmio_pkg::RX_START: begin
          if (baud_cnt == mmio_pkg::BAUD_HALF) begin
            baud_cnt <= '0;
            bit_idx  <= '0;
            // Glitch, not a real start bit
            state    <= rxd_sync ? mmio_pkg::RX_IDLE : mmio_pkg::RX_DATA;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        mmio_pkg::RX_DATA: begin
          if (baud_cnt == mmio_pkg::BAUD_LAST) begin
            baud_cnt <= '0;
            if (bit_idx == mmio_pkg::RX_LAST_DATA) begin
              state <= mmio_pkg::RX_STOP;
            end else begin
              bit_idx <= bit_idx + 3'd1;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: begin
          // Framing error just drops the byte
          if (baud_cnt == mmio_pkg::BAUD_LAST) begin
            state <= mmio_pkg::RX_IDLE;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if ((state == mmio_pkg::RX_DATA) && (baud_cnt == mmio_pkg::BAUD_LAST)) begin
      shift <= {rxd_sync, shift[7:1]};
    end
    if (frame_done) begin
      rx_byte <= shift;
    end
  end

  // Held until popped; a new frame wins over a pop
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_valid <= 1'b0;
    end else if (frame_done) begin
      rx_valid <= 1'b1;
    end else if (rx_ready) begin
      rx_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: perf_counters.sv
`timescale 1ns/10ps
`default_nettype none

module perf_counters (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        clear,
  input  logic                        inst_retired,
  output logic [mmio_pkg::DWIDTH-1:0] cycle_cnt,
  output logic [mmio_pkg::DWIDTH-1:0] inst_cnt
);

  // Free-running cycle count, wraps at the top
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  // One count per retired instruction
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      inst_cnt <= '0;
    end else if (inst_retired) begin
      inst_cnt <= inst_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: mmio_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_subsystem (
  input  logic                        clk,
  input  logic                        rst,
  input  mmio_pkg::mmio_req_t         req,
  input  logic                        inst_retired,
  input  logic                        uart_rxd,
  output logic [mmio_pkg::DWIDTH-1:0] rdata,
  output logic                        uart_txd
);

  mmio_pkg::uart_ctrl_t        uart_ctrl;
  mmio_pkg::uart_stat_t        uart_stat;
  logic                        cnt_clear;
  logic [mmio_pkg::DWIDTH-1:0] cycle_cnt;
  logic [mmio_pkg::DWIDTH-1:0] inst_cnt;
  logic                        tx_ready;
  logic                        rx_valid;
  logic [7:0]                  rx_byte;

  // UART status bundle for the decoder
  assign uart_stat = '{tx_ready: tx_ready, rx_valid: rx_valid, rx_byte: rx_byte};

  mmio_decode mmio_decode_i (
    .req       (req),
    .uart_stat (uart_stat),
    .cycle_cnt (cycle_cnt),
    .inst_cnt  (inst_cnt),
    .uart_ctrl (uart_ctrl),
    .cnt_clear (cnt_clear),
    .rdata     (rdata)
  );

  uart_tx uart_tx_i (
    .clk       (clk),
    .rst       (rst),
    .uart_ctrl (uart_ctrl),
    .tx_ready  (tx_ready),
    .txd       (uart_txd)
  );

  uart_rx uart_rx_i (
    .clk      (clk),
    .rst      (rst),
    .rxd      (uart_rxd),
    .rx_ready (uart_ctrl.rx_ready),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte)
  );

  perf_counters perf_counters_i (
    .clk          (clk),
    .rst          (rst),
    .clear        (cnt_clear),
    .inst_retired (inst_retired),
    .cycle_cnt    (cycle_cnt),
    .inst_cnt     (inst_cnt)
  );

endmodule

`default_nettype wire

// File: mmio_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_tb;

  localparam logic [2:0] OP_WRITE   = 3'd0;
  localparam logic [2:0] OP_READ    = 3'd1;
  localparam logic [2:0] OP_WAIT_RX = 3'd2;
  localparam logic [2:0] OP_IDLE    = 3'd3;
  localparam logic [2:0] OP_NO_RX   = 3'd4;

  localparam int RX_WAIT_LIMIT   = 12 * mmio_pkg::CLKS_PER_BIT;
  localparam int TX_FRAME_CYCLES = 10 * mmio_pkg::CLKS_PER_BIT;

  typedef struct packed {
    logic [2:0]  kind;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] expected;
  } step_t;

  logic                        clk;
  logic                        rst;
  mmio_pkg::mmio_req_t         req;
  logic                        inst_retired;
  logic                        uart_rxd;
  logic [mmio_pkg::DWIDTH-1:0] rdata;
  logic                        uart_txd;
  logic                        loopback_en;

  step_t       steps[$];
  string       step_names[$];
  logic [7:0]  sent_bytes[$];
  logic [31:0] cyc_model;
  logic [31:0] inst_model;
  int          tx_busy_left;
  logic        rx_seen;
  integer      seed;
  integer      rnd_bits;
  int          errors;
  int          checks;
  int          cycle_count;
  int          cycle_limit;

  mmio_subsystem mmio_subsystem_i (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .inst_retired (inst_retired),
    .uart_rxd     (uart_rxd),
    .rdata        (rdata),
    .uart_txd     (uart_txd)
  );

  // Serial loopback, line held idle until reset is over
  assign uart_rxd = loopback_en ? uart_txd : 1'b1;

  always #5 clk = ~clk;

  // Random retire pulses
  always @(posedge clk) begin
    #1;
    rnd_bits = $random(seed);
    inst_retired = rnd_bits[0];
  end

  // Counter and transmitter busy models
  always @(posedge clk) begin
    if (rst || (req.we && (req.addr == mmio_pkg::ADDR_CNT_RST))) begin
      cyc_model  <= '0;
      inst_model <= '0;
    end else begin
      cyc_model <= cyc_model + 32'd1;
      if (inst_retired) begin
        inst_model <= inst_model + 32'd1;
      end
    end
    if (rst) begin
      tx_busy_left <= 0;
    end else if (req.we && (req.addr == mmio_pkg::ADDR_UART_TX) && (tx_busy_left == 0)) begin
      tx_busy_left <= TX_FRAME_CYCLES;
    end else if (tx_busy_left != 0) begin
      tx_busy_left <= tx_busy_left - 1;
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run went past %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic add_step(input string name, input logic [2:0] kind, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [31:0] expected);
    step_t st;
    st.kind     = kind;
    st.addr     = addr;
    st.wdata    = wdata;
    st.expected = expected;
    steps.push_back(st);
    step_names.push_back(name);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks = checks + 1;
    if (actual !== expected) begin
      $display("Fail %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      errors = errors + 1;
    end
  endtask

  task automatic drive_req(input logic [31:0] addr, input logic [31:0] wdata, input logic re,
                           input logic we);
    @(posedge clk);
    #1;
    req.addr  = addr;
    req.wdata = wdata;
    req.re    = re;
    req.we    = we;
  endtask

  // Poll status until rx_valid shows up or the wait runs out
  task automatic poll_rx_valid(output logic seen);
    int n;
    n = 0;
    seen = 1'b0;
    while (!seen && (n < RX_WAIT_LIMIT)) begin
      drive_req(mmio_pkg::ADDR_UART_STAT, '0, 1'b1, 1'b0);
      @(negedge clk);
      seen = rdata[1];
      n = n + 1;
    end
  endtask

  task automatic build_table();
    int stretch;
    add_step("stat_after_reset", OP_READ, mmio_pkg::ADDR_UART_STAT, '0, 32'd1);
    add_step("cycle_after_reset", OP_READ, mmio_pkg::ADDR_CYCLE_CNT, '0, '0);
    add_step("inst_after_reset", OP_READ, mmio_pkg::ADDR_INST_CNT, '0, '0);
    add_step("tx_write_a5", OP_WRITE, mmio_pkg::ADDR_UART_TX, 32'h0000_00a5, '0);
    add_step("wait_rx_a5", OP_WAIT_RX, '0, '0, '0);
    add_step("pop_a5", OP_READ, mmio_pkg::ADDR_UART_RX, '0, '0);
    add_step("stat_after_pop", OP_READ, mmio_pkg::ADDR_UART_STAT, '0, 32'd1);
    // Second write lands while the first frame is still going out
    add_step("tx_write_5a", OP_WRITE, mmio_pkg::ADDR_UART_TX, 32'h0000_015a, '0);
    add_step("tx_write_busy", OP_WRITE, mmio_pkg::ADDR_UART_TX, 32'h0000_00c3, '0);
    add_step("wait_rx_5a", OP_WAIT_RX, '0, '0, '0);
    add_step("pop_5a", OP_READ, mmio_pkg::ADDR_UART_RX, '0, '0);
    add_step("no_second_byte", OP_NO_RX, '0, '0, '0);
    add_step("stat_after_drop", OP_READ, mmio_pkg::ADDR_UART_STAT, '0, 32'd1);
    add_step("cnt_clear", OP_WRITE, mmio_pkg::ADDR_CNT_RST, '0, '0);
    add_step("cycle_after_clear", OP_READ, mmio_pkg::ADDR_CYCLE_CNT, '0, '0);
    add_step("inst_after_clear", OP_READ, mmio_pkg::ADDR_INST_CNT, '0, '0);
    stretch = ($random(seed) & 15) + 4;
    add_step("idle_1", OP_IDLE, '0, stretch, '0);
    add_step("cycle_after_idle_1", OP_READ, mmio_pkg::ADDR_CYCLE_CNT, '0, '0);
    add_step("inst_after_idle_1", OP_READ, mmio_pkg::ADDR_INST_CNT, '0, '0);
    stretch = ($random(seed) & 15) + 4;
    add_step("idle_2", OP_IDLE, '0, stretch, '0);
    add_step("cycle_after_idle_2", OP_READ, mmio_pkg::ADDR_CYCLE_CNT, '0, '0);
    add_step("inst_after_idle_2", OP_READ, mmio_pkg::ADDR_INST_CNT, '0, '0);
    add_step("unmapped_read", OP_READ, 32'h8000_0020, '0, '0);
    add_step("unmapped_low_alias", OP_READ, 32'h0000_0010, '0, '0);
    add_step("rx_read_empty", OP_READ, mmio_pkg::ADDR_UART_RX, '0, '0);
    add_step("write_cycle_addr", OP_WRITE, mmio_pkg::ADDR_CYCLE_CNT, 32'hdead_beef, '0);
    add_step("cycle_after_write", OP_READ, mmio_pkg::ADDR_CYCLE_CNT, '0, '0);
    add_step("write_inst_addr", OP_WRITE, mmio_pkg::ADDR_INST_CNT, 32'h1234_5678, '0);
    add_step("inst_after_write", OP_READ, mmio_pkg::ADDR_INST_CNT, '0, '0);
    add_step("stat_final", OP_READ, mmio_pkg::ADDR_UART_STAT, '0, 32'd1);
  endtask

  task automatic apply_step(input int idx);
    step_t       st;
    string       name;
    logic [31:0] expected;
    logic        seen;
    st = steps[idx];
    name = step_names[idx];
    expected = st.expected;
    case (st.kind)
      OP_WRITE: begin
        drive_req(st.addr, st.wdata, 1'b0, 1'b1);
        // Only a write to an idle transmitter is sent
        if ((st.addr == mmio_pkg::ADDR_UART_TX) && (tx_busy_left == 0)) begin
          sent_bytes.push_back(st.wdata[7:0]);
        end
        @(negedge clk);
      end
      OP_READ: begin
        drive_req(st.addr, '0, 1'b1, 1'b0);
        @(negedge clk);
        if (st.addr == mmio_pkg::ADDR_CYCLE_CNT) begin
          expected = cyc_model;
        end else if (st.addr == mmio_pkg::ADDR_INST_CNT) begin
          expected = inst_model;
        end else if ((st.addr == mmio_pkg::ADDR_UART_RX) && rx_seen && (sent_bytes.size() > 0)) begin
          expected = {24'h0, sent_bytes.pop_front()};
          rx_seen = 1'b0;
        end
        check_value(name, expected, rdata);
      end
      OP_WAIT_RX: begin
        poll_rx_valid(seen);
        if (seen) begin
          rx_seen = 1'b1;
        end else begin
          $display("Error %s: no byte arrived within %0d cycles", name, RX_WAIT_LIMIT);
          errors = errors + 1;
        end
      end
      OP_NO_RX: begin
        poll_rx_valid(seen);
        if (seen) begin
          $display("Error %s: a byte arrived although the write was dropped", name);
          errors = errors + 1;
        end
      end
      default: begin
        repeat (int'(st.wdata)) drive_req('0, '0, 1'b0, 1'b0);
      end
    endcase
  endtask

  initial begin
    seed = 73;
    errors = 0;
    checks = 0;
    cycle_count = 0;
    clk = 1'b0;
    rst = 1'b1;
    req = '0;
    inst_retired = 1'b0;
    loopback_en = 1'b0;
    rx_seen = 1'b0;
    build_table();
    cycle_limit = steps.size() * 12 * mmio_pkg::CLKS_PER_BIT + 200;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    loopback_en = 1'b1;
    for (int i = 0; i < steps.size(); i++) begin
      apply_step(i);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
mmio_pkg.sv
mmio_decode.sv
uart_tx.sv
uart_rx.sv
perf_counters.sv
mmio_subsystem.sv
mmio_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the MMIO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps \
  -f compile.f --top-module mmio_tb -o mmio_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/mmio_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
  exit 0
fi
exit 1
